//--- Makefile
# Verilator build and run for the LDPC decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash without a pass line also fails
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/cnu.sv
`timescale 1ns/1ps

module cnu (
    input  logic [ldpc_pkg::BC*ldpc_pkg::LLR_W-1:0] v2c_in,
    output logic [ldpc_pkg::BC*ldpc_pkg::LLR_W-1:0] c2v_out
);

    logic signed [ldpc_pkg::LLR_W-1:0] msg [ldpc_pkg::BC];
    logic [ldpc_pkg::LLR_W-1:0] mag [ldpc_pkg::BC];
    logic [ldpc_pkg::BC-1:0] sgn;
    logic [ldpc_pkg::LLR_W-1:0] min1;
    logic [ldpc_pkg::LLR_W-1:0] min2;
    logic [ldpc_pkg::CIDX_W-1:0] min_idx;
    logic parity;

    always_comb begin
        for (int k = 0; k < ldpc_pkg::BC; k++) begin
            msg[k] = v2c_in[k*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W];
            sgn[k] = msg[k][ldpc_pkg::LLR_W-1];
            mag[k] = sgn[k] ? -msg[k] : msg[k];   // Unsigned, so -16 reads as 16
        end
    end

    // Two smallest magnitudes and where the smallest sits
    always_comb begin
        min1 = '1;
        min2 = '1;
        min_idx = '0;
        for (int k = 0; k < ldpc_pkg::BC; k++) begin
            if (mag[k] < min1) begin
                min2 = min1;
                min1 = mag[k];
                min_idx = ldpc_pkg::CIDX_W'(k);
            end else if (mag[k] < min2) begin
                min2 = mag[k];
            end
        end
    end

    assign parity = ^sgn;

    always_comb begin
        logic [ldpc_pkg::LLR_W-1:0] sel;
        for (int k = 0; k < ldpc_pkg::BC; k++) begin
            sel = (ldpc_pkg::CIDX_W'(k) == min_idx) ? min2 : min1;   // Exclude own edge
            if (sel > ldpc_pkg::MSG_MAX)
                sel = ldpc_pkg::LLR_W'(ldpc_pkg::MSG_MAX);
            c2v_out[k*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = (parity ^ sgn[k]) ? -sel : sel;
        end
    end

    // A VNU that fails to saturate shows up here as a -16 input
    always_comb begin
        for (int k = 0; k < ldpc_pkg::BC; k++) begin
            assert (mag[k] <= ldpc_pkg::MSG_MAX)
                else $error("cnu input magnitude above MSG_MAX on edge %0d", k);
        end
    end

endmodule

//--- rtl/cnu_bank.sv
`timescale 1ns/1ps

module cnu_bank (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic step,
    input  logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] v2c,
    output logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] c2v
);

    logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] c2v_next;
    logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] c2v_q;   // Held in check order

    // v2c arrives grouped by check, four edges each
    for (genvar c = 0; c < ldpc_pkg::N_CHK; c++) begin : g_chk
        cnu u_cnu (
            .v2c_in  (v2c[c*ldpc_pkg::BC*ldpc_pkg::LLR_W +: ldpc_pkg::BC*ldpc_pkg::LLR_W]),
            .c2v_out (c2v_next[c*ldpc_pkg::BC*ldpc_pkg::LLR_W +: ldpc_pkg::BC*ldpc_pkg::LLR_W])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            c2v_q <= '0;
        end else if (start) begin
            c2v_q <= '0;   // Fresh frame starts from channel LLRs alone
        end else if (step) begin
            c2v_q <= c2v_next;
        end
    end

    // Regroup by variable through the shift table, two block rows per variable
    for (genvar v = 0; v < ldpc_pkg::N_VAR; v++) begin : g_var
        for (genvar i = 0; i < ldpc_pkg::BR; i++) begin : g_row
            assign c2v[(v*ldpc_pkg::BR+i)*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] =
                c2v_q[ldpc_pkg::edge_of(v, i)*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W];
        end
    end

endmodule

//--- rtl/ldpc_decoder.sv
`timescale 1ns/1ps

module ldpc_decoder (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] in_llr,
    output logic in_credit,
    output logic out_valid,
    output logic [ldpc_pkg::N_VAR-1:0] out_bits,
    output logic [ldpc_pkg::ITER_W-1:0] out_iters,
    output logic out_ok,
    input  logic out_credit
);

    logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] q_mem [ldpc_pkg::IN_CREDITS];
    logic [ldpc_pkg::Q_PTR_W-1:0] q_wr;
    logic [ldpc_pkg::Q_PTR_W-1:0] q_rd;
    logic [ldpc_pkg::Q_CNT_W-1:0] q_cnt;

    logic busy;
    logic hold;    // Finished result waiting for an output credit
    logic [ldpc_pkg::ITER_W-1:0] iter;
    logic [ldpc_pkg::OCR_W-1:0] out_cnt;
    logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] chan_llr;

    logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] v2c;
    logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] c2v;
    logic [ldpc_pkg::N_VAR-1:0] dec;
    logic syn_zero;

    logic load;
    logic finish;
    logic step;
    logic issue;

    // A new frame only loads once the previous result has left
    assign load   = !busy && !hold && !out_valid && (q_cnt != '0);
    assign finish = busy && (syn_zero || iter == ldpc_pkg::ITER_W'(ldpc_pkg::MAX_ITER));
    assign step   = busy && !finish;
    assign issue  = (finish || hold) && (out_cnt != '0);
    assign in_credit = load;

    always_ff @(posedge clk) begin
        if (in_valid)
            q_mem[q_wr] <= in_llr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_cnt <= '0;
        end else begin
            if (in_valid)
                q_wr <= q_wr + 1'b1;
            if (load)
                q_rd <= q_rd + 1'b1;
            q_cnt <= q_cnt + ldpc_pkg::Q_CNT_W'(in_valid) - ldpc_pkg::Q_CNT_W'(load);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            hold      <= 1'b0;
            iter      <= '0;
            out_valid <= 1'b0;
            out_cnt   <= ldpc_pkg::OCR_W'(ldpc_pkg::OUT_CREDITS);
        end else begin
            out_valid <= issue;
            out_cnt   <= out_cnt - ldpc_pkg::OCR_W'(issue) + ldpc_pkg::OCR_W'(out_credit);
            if (load) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (step) begin
                iter <= iter + 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
                hold <= !issue;
            end else if (hold && issue) begin
                hold <= 1'b0;
            end
        end
    end

    // Frame and result payload
    always_ff @(posedge clk) begin
        if (load)
            chan_llr <= q_mem[q_rd];
        if (finish) begin
            out_bits  <= dec;
            out_iters <= iter;   // CNU updates done so far
            out_ok    <= syn_zero;
        end
    end

    cnu_bank u_cnu_bank (
        .clk   (clk),
        .rst   (rst),
        .start (load),
        .step  (step),
        .v2c   (v2c),
        .c2v   (c2v)
    );

    vnu_bank u_vnu_bank (
        .chan_llr (chan_llr),
        .c2v      (c2v),
        .v2c      (v2c),
        .dec      (dec)
    );

    syndrome_check u_syndrome_check (
        .dec      (dec),
        .syn_zero (syn_zero)
    );

    // Source must respect the two input credits
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> q_cnt < ldpc_pkg::IN_CREDITS);

    a_out_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(out_cnt) != '0);

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        out_cnt <= ldpc_pkg::OUT_CREDITS);

endmodule

//--- rtl/ldpc_pkg.sv
package ldpc_pkg;

    // Base matrix geometry and lifting
    localparam int Z     = 4;
    localparam int BR    = 2;
    localparam int BC    = 4;
    localparam int N_VAR = BC * Z;
    localparam int N_CHK = BR * Z;
    localparam int N_EDGE = N_CHK * BC;   // Every base entry is present

    // Messages are signed, positive means bit 0
    localparam int LLR_W   = 5;
    localparam int MSG_MAX = 15;
    localparam int SUM_W   = 8;
    localparam int CIDX_W  = $clog2(BC);

    // Cyclic shift per base entry, indexed [block row][block column]
    localparam int SHIFT [BR][BC] = '{'{0, 1, 2, 3}, '{2, 0, 3, 1}};

    localparam int MAX_ITER = 8;
    localparam int ITER_W   = 4;

    localparam int IN_CREDITS  = 2;
    localparam int OUT_CREDITS = 2;
    localparam int Q_PTR_W     = $clog2(IN_CREDITS);
    localparam int Q_CNT_W     = $clog2(IN_CREDITS + 1);
    localparam int OCR_W       = $clog2(OUT_CREDITS + 1);

    // Variable attached to column col of check chk
    function automatic int var_of(int chk, int col);
        return col * Z + ((chk % Z) + SHIFT[chk / Z][col]) % Z;
    endfunction

    // Check-ordered edge index of variable vidx in block row row
    function automatic int edge_of(int vidx, int row);
        int col;
        int t;
        col = vidx / Z;
        t = vidx % Z;
        return (row * Z + (t - SHIFT[row][col] + Z) % Z) * BC + col;
    endfunction

endpackage

//--- rtl/syndrome_check.sv
`timescale 1ns/1ps

module syndrome_check (
    input  logic [ldpc_pkg::N_VAR-1:0] dec,
    output logic syn_zero
);

    logic [ldpc_pkg::N_CHK-1:0] parity;

    for (genvar c = 0; c < ldpc_pkg::N_CHK; c++) begin : g_chk
        logic [ldpc_pkg::BC-1:0] bits;

        // One connected bit from each block column
        for (genvar j = 0; j < ldpc_pkg::BC; j++) begin : g_col
            assign bits[j] = dec[ldpc_pkg::var_of(c, j)];
        end

        assign parity[c] = ^bits;
    end

    assign syn_zero = ~|parity;   // Valid codeword when every check is even

endmodule

//--- rtl/vnu.sv
`timescale 1ns/1ps

module vnu (
    input  logic signed [ldpc_pkg::LLR_W-1:0] llr,
    input  logic [ldpc_pkg::BR*ldpc_pkg::LLR_W-1:0] c2v_in,
    output logic [ldpc_pkg::BR*ldpc_pkg::LLR_W-1:0] v2c_out,
    output logic dec
);

    logic signed [ldpc_pkg::LLR_W-1:0] cin [ldpc_pkg::BR];
    logic signed [ldpc_pkg::SUM_W-1:0] total;
    logic signed [ldpc_pkg::SUM_W-1:0] ext [ldpc_pkg::BR];

    always_comb begin
        total = ldpc_pkg::SUM_W'(llr);
        for (int k = 0; k < ldpc_pkg::BR; k++) begin
            cin[k] = c2v_in[k*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W];
            total = total + ldpc_pkg::SUM_W'(cin[k]);
        end
    end

    assign dec = total[ldpc_pkg::SUM_W-1];   // Negative total decides a 1

    // Extrinsic message per edge, clamped to the message range
    always_comb begin
        for (int k = 0; k < ldpc_pkg::BR; k++) begin
            ext[k] = total - ldpc_pkg::SUM_W'(cin[k]);
            if (ext[k] > ldpc_pkg::MSG_MAX)
                ext[k] = ldpc_pkg::SUM_W'(ldpc_pkg::MSG_MAX);
            else if (ext[k] < -ldpc_pkg::MSG_MAX)
                ext[k] = ldpc_pkg::SUM_W'(-ldpc_pkg::MSG_MAX);
            v2c_out[k*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = ldpc_pkg::LLR_W'(ext[k]);
        end
    end

endmodule

//--- rtl/vnu_bank.sv
`timescale 1ns/1ps

module vnu_bank (
    input  logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] chan_llr,
    input  logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] c2v,
    output logic [ldpc_pkg::N_EDGE*ldpc_pkg::LLR_W-1:0] v2c,
    output logic [ldpc_pkg::N_VAR-1:0] dec
);

    for (genvar v = 0; v < ldpc_pkg::N_VAR; v++) begin : g_var
        logic [ldpc_pkg::BR*ldpc_pkg::LLR_W-1:0] v_out;

        // c2v is grouped by variable, one message per block row
        vnu u_vnu (
            .llr     (chan_llr[v*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W]),
            .c2v_in  (c2v[v*ldpc_pkg::BR*ldpc_pkg::LLR_W +: ldpc_pkg::BR*ldpc_pkg::LLR_W]),
            .v2c_out (v_out),
            .dec     (dec[v])
        );

        // Inverse shift puts each message back on its check edge
        for (genvar i = 0; i < ldpc_pkg::BR; i++) begin : g_row
            assign v2c[ldpc_pkg::edge_of(v, i)*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] =
                v_out[i*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W];
        end
    end

endmodule

//--- tb.f
rtl/ldpc_pkg.sv
rtl/cnu.sv
rtl/cnu_bank.sv
rtl/vnu.sv
rtl/vnu_bank.sv
rtl/syndrome_check.sv
rtl/ldpc_decoder.sv
tb/ldpc_checker.sv
tb/tb_top.sv

//--- tb/ldpc_checker.sv
`timescale 1ns/1ps

module ldpc_checker (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] in_llr,
    input logic in_credit,
    input logic out_valid,
    input logic [ldpc_pkg::N_VAR-1:0] out_bits,
    input logic [ldpc_pkg::ITER_W-1:0] out_iters,
    input logic out_ok,
    input logic out_credit
);

    logic [ldpc_pkg::N_VAR-1:0] exp_bits [$];
    int exp_iters [$];
    bit exp_ok [$];
    string test_name = "none";
    int errors = 0;
    int test_errors = 0;
    int test_frames = 0;
    int checks = 0;
    int frames_in = 0;
    int credit_pulses = 0;
    int in_avail = ldpc_pkg::IN_CREDITS;
    int out_avail = ldpc_pkg::OUT_CREDITS;

    // Check chk touches one variable in block column col
    function automatic int column_var(int chk, int col);
        int r;
        r = (chk % ldpc_pkg::Z + ldpc_pkg::SHIFT[chk / ldpc_pkg::Z][col]) % ldpc_pkg::Z;
        return col * ldpc_pkg::Z + r;
    endfunction

    function automatic int clamp_msg(int x);
        if (x > ldpc_pkg::MSG_MAX)
            return ldpc_pkg::MSG_MAX;
        if (x < -ldpc_pkg::MSG_MAX)
            return -ldpc_pkg::MSG_MAX;
        return x;
    endfunction

    // Flooding min-sum, one CNU update per pass until parity holds or the limit
    function automatic void decode_model(input logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] frame,
                                         output logic [ldpc_pkg::N_VAR-1:0] bits,
                                         output int iters, output bit ok);
        int total [ldpc_pkg::N_VAR];
        int c2v [ldpc_pkg::N_CHK][ldpc_pkg::BC];
        int v2c [ldpc_pkg::N_CHK][ldpc_pkg::BC];
        int m;
        int mag;
        bit neg;
        bit par;
        bit done;
        for (int c = 0; c < ldpc_pkg::N_CHK; c++)
            for (int j = 0; j < ldpc_pkg::BC; j++)
                c2v[c][j] = 0;
        iters = 0;
        ok = 1'b0;
        bits = '0;
        done = 1'b0;
        while (!done) begin
            for (int v = 0; v < ldpc_pkg::N_VAR; v++)
                total[v] = int'($signed(frame[v*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W]));
            for (int c = 0; c < ldpc_pkg::N_CHK; c++)
                for (int j = 0; j < ldpc_pkg::BC; j++)
                    total[column_var(c, j)] += c2v[c][j];
            for (int v = 0; v < ldpc_pkg::N_VAR; v++)
                bits[v] = total[v] < 0;
            ok = 1'b1;
            for (int c = 0; c < ldpc_pkg::N_CHK; c++) begin
                par = 1'b0;
                for (int j = 0; j < ldpc_pkg::BC; j++)
                    par ^= bits[column_var(c, j)];
                if (par)
                    ok = 1'b0;
            end
            if (ok || iters == ldpc_pkg::MAX_ITER) begin
                done = 1'b1;
            end else begin
                for (int c = 0; c < ldpc_pkg::N_CHK; c++)
                    for (int j = 0; j < ldpc_pkg::BC; j++)
                        v2c[c][j] = clamp_msg(total[column_var(c, j)] - c2v[c][j]);
                for (int c = 0; c < ldpc_pkg::N_CHK; c++) begin
                    for (int j = 0; j < ldpc_pkg::BC; j++) begin
                        m = ldpc_pkg::MSG_MAX;
                        neg = 1'b0;
                        for (int k = 0; k < ldpc_pkg::BC; k++) begin
                            if (k != j) begin
                                mag = (v2c[c][k] < 0) ? -v2c[c][k] : v2c[c][k];
                                if (mag < m)
                                    m = mag;
                                if (v2c[c][k] < 0)
                                    neg = !neg;
                            end
                        end
                        c2v[c][j] = neg ? -m : m;
                    end
                end
                iters++;
            end
        end
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        test_frames = 0;
    endtask

    task automatic flag_error(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_equal(input string what, input int expected, input int actual,
                               input bit as_hex);
        checks++;
        if (expected != actual) begin
            if (as_hex)
                $display("Fail %s %s: expected %0h actual %0h", test_name, what, expected, actual);
            else
                $display("Fail %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test();
        check_equal("in_credit pulses", frames_in, credit_pulses, 1'b0);
        check_equal("results missing", 0, exp_bits.size(), 1'b0);
        $display("%s: done, %0d frames, %0d errors", test_name, test_frames, test_errors);
    endtask

    // Sampled mid-cycle, well away from the drive edge
    always @(negedge clk) begin
        logic [ldpc_pkg::N_VAR-1:0] bits;
        int iters;
        bit ok;
        if (rst) begin
            in_avail = ldpc_pkg::IN_CREDITS;
            out_avail = ldpc_pkg::OUT_CREDITS;
        end else begin
            if (in_valid) begin
                if (in_avail == 0)
                    flag_error("frame sent without an input credit");
                in_avail--;
                frames_in++;
                decode_model(in_llr, bits, iters, ok);
                exp_bits.push_back(bits);
                exp_iters.push_back(iters);
                exp_ok.push_back(ok);
            end
            if (in_credit) begin
                credit_pulses++;
                in_avail++;
                if (in_avail > ldpc_pkg::IN_CREDITS)
                    flag_error("in_credit pulsed with no frame outstanding");
            end
            if (out_valid) begin
                if (out_avail == 0)
                    flag_error("result sent without an output credit");
                out_avail--;
                if (exp_bits.size() == 0) begin
                    flag_error("result arrived with no frame outstanding");
                end else begin
                    test_frames++;
                    bits = exp_bits.pop_front();
                    iters = exp_iters.pop_front();
                    ok = exp_ok.pop_front();
                    check_equal($sformatf("frame %0d bits", test_frames),
                                int'(bits), int'(out_bits), 1'b1);
                    check_equal($sformatf("frame %0d iters", test_frames),
                                iters, int'(out_iters), 1'b0);
                    check_equal($sformatf("frame %0d ok", test_frames),
                                int'(ok), int'(out_ok), 1'b0);
                end
            end
            if (out_credit)
                out_avail++;   // Usable from the next result on
        end
    end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int DRIVE_DLY  = 2;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic rst;
    logic in_valid;
    logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] in_llr;
    logic in_credit;
    logic out_valid;
    logic [ldpc_pkg::N_VAR-1:0] out_bits;
    logic [ldpc_pkg::ITER_W-1:0] out_iters;
    logic out_ok;
    logic out_credit;

    int src_credits = ldpc_pkg::IN_CREDITS;
    int frames_sent = 0;
    int outs_seen = 0;
    int owed = 0;          // Output credits the sink still has to return
    bit sink_hold = 1'b0;
    bit give_next = 1'b0;
    bit aborted = 1'b0;
    logic [ldpc_pkg::N_VAR-1:0] last_bits;
    int last_iters;
    bit last_ok;

    ldpc_decoder dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_llr     (in_llr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_bits   (out_bits),
        .out_iters  (out_iters),
        .out_ok     (out_ok),
        .out_credit (out_credit)
    );

    ldpc_checker chk (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_llr     (in_llr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_bits   (out_bits),
        .out_iters  (out_iters),
        .out_ok     (out_ok),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Credit bookkeeping for both sides, decided at the falling edge
    always @(negedge clk) begin
        if (in_credit)
            src_credits++;
        if (out_valid) begin
            outs_seen++;
            owed++;
            last_bits = out_bits;
            last_iters = int'(out_iters);
            last_ok = out_ok;
        end
        give_next = 1'b0;
        if (!rst && !sink_hold && owed > 0 && $urandom_range(3) == 0) begin
            give_next = 1'b1;
            owed--;
        end
    end

    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            out_credit = give_next;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        aborted = 1'b1;
    endtask

    task automatic send_frame(input logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] llr);
        int waited;
        waited = 0;
        while (src_credits == 0 && !aborted) begin
            next_cycle();
            waited++;
            if (waited == WAIT_LIMIT)
                report_timeout("an input credit");
        end
        if (!aborted) begin
            in_valid = 1'b1;
            in_llr = llr;
            src_credits--;
            frames_sent++;
            next_cycle();
            in_valid = 1'b0;
        end
    endtask

    // All results in and every output credit handed back
    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((outs_seen < frames_sent || owed > 0 || give_next) && !aborted) begin
            next_cycle();
            waited++;
            if (waited == WAIT_LIMIT)
                report_timeout("outstanding results");
        end
        next_cycle();
    endtask

    function automatic logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] clean_frame();
        logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] f;
        for (int v = 0; v < ldpc_pkg::N_VAR; v++)
            f[v*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = ldpc_pkg::LLR_W'(ldpc_pkg::MSG_MAX);
        return f;
    endfunction

    // All-zero codeword seen through noise, with a few bits pushed the wrong way
    function automatic logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] noisy_frame(int flips);
        logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] f;
        int val;
        int idx;
        for (int v = 0; v < ldpc_pkg::N_VAR; v++) begin
            val = int'($urandom_range(15, 3));
            f[v*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = ldpc_pkg::LLR_W'(val);
        end
        for (int k = 0; k < flips; k++) begin
            idx = int'($urandom_range(ldpc_pkg::N_VAR - 1));
            val = -int'($urandom_range(8, 1));
            f[idx*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = ldpc_pkg::LLR_W'(val);
        end
        return f;
    endfunction

    function automatic logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] uniform_frame();
        logic [ldpc_pkg::N_VAR*ldpc_pkg::LLR_W-1:0] f;
        int val;
        for (int v = 0; v < ldpc_pkg::N_VAR; v++) begin
            val = int'($urandom_range(30)) - ldpc_pkg::MSG_MAX;
            f[v*ldpc_pkg::LLR_W +: ldpc_pkg::LLR_W] = ldpc_pkg::LLR_W'(val);
        end
        return f;
    endfunction

    task automatic run_tests();
        int base;
        chk.begin_test("reset_and_clean");
        repeat (10) next_cycle();   // The checker flags any credit or result pulse while idle
        send_frame(clean_frame());
        wait_idle();
        chk.check_equal("bits", 0, int'(last_bits), 1'b1);
        chk.check_equal("iters", 0, last_iters, 1'b0);
        chk.check_equal("ok", 1, int'(last_ok), 1'b0);
        chk.end_test();
        if (aborted)
            return;

        chk.begin_test("noisy_codeword");
        for (int i = 0; i < 100 && !aborted; i++)
            send_frame(noisy_frame(int'($urandom_range(3))));
        wait_idle();
        chk.end_test();
        if (aborted)
            return;

        chk.begin_test("uniform_llr");
        for (int i = 0; i < 30 && !aborted; i++)
            send_frame(uniform_frame());
        wait_idle();
        chk.end_test();
        if (aborted)
            return;

        chk.begin_test("output_backpressure");
        base = outs_seen;
        sink_hold = 1'b1;
        for (int i = 0; i < 5 && !aborted; i++)
            send_frame(noisy_frame(1));
        repeat (100) next_cycle();   // Long enough for every credited result to leave
        chk.check_equal("results under hold", ldpc_pkg::OUT_CREDITS, outs_seen - base, 1'b0);
        sink_hold = 1'b0;
        wait_idle();
        chk.end_test();
        if (aborted)
            return;

        chk.begin_test("input_credits");
        for (int i = 0; i < 20 && !aborted; i++)
            send_frame(noisy_frame(2));
        wait_idle();
        chk.end_test();
    endtask

    initial begin
        void'($urandom(75));
        rst = 1'b1;
        in_valid = 1'b0;
        in_llr = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        run_tests();
        $display("Frames %0d, results %0d, checks %0d, errors %0d, timeouts %0d",
                 frames_sent, outs_seen, chk.checks, chk.errors, int'(aborted));
        if (aborted || chk.errors != 0)
            $display("TEST FAILED");
        else
            $display("TEST PASSED");
        $finish;
    end

endmodule
